// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= nbbpu_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== flist.f ====
+incdir+src
src/nbbpu_pkg.sv
src/controller.sv
src/regfile.sv
src/alu.sv
src/fetch_unit.sv
src/nbbpu.sv
verification/nbbpu_asserts.sv
verification/nbbpu_tb.sv

// ==== src/alu.sv ====
// -------------------------------------------------------------------------
// Single ALU. Computes the result of the current opcode and holds it from
// the end of EXECUTE through STORE for the register file, RAM and PC.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic               clock,
    input  logic               reset,
    input  nbbpu_pkg::ctrl_t   ctrl,
    input  nbbpu_pkg::instr_t  instr,
    input  nbbpu_pkg::word_t   x_value,
    input  nbbpu_pkg::word_t   y_value,
    input  nbbpu_pkg::word_t   read_data,
    input  nbbpu_pkg::word_t   pc,
    output nbbpu_pkg::word_t   result
);
    import nbbpu_pkg::*;

    word_t      next_result;
    logic [7:0] immediate;
    logic [3:0] shift;
    logic       y_zero;

    // Byte immediate spans the x and y fields
    assign immediate = {instr.x, instr.y};
    assign shift     = y_value[3:0];
    assign y_zero    = (y_value == '0);

    // ---------------------------------------------------------------------
    // Result select
    // ---------------------------------------------------------------------

    always_comb
    begin
        case (instr.opcode)
            OP_AND:   next_result = x_value & y_value;
            OP_OR:    next_result = x_value | y_value;
            OP_XOR:   next_result = x_value ^ y_value;
            OP_NOT:   next_result = ~x_value;
            OP_ADD:   next_result = x_value + y_value;
            OP_SUB:   next_result = x_value - y_value;
            OP_SHL:   next_result = x_value << shift;
            OP_SHR:   next_result = x_value >> shift;
            OP_SETL:  next_result = {x_value[15:8], immediate}; // x_value is reg z here
            OP_SETH:  next_result = {immediate, x_value[7:0]};
            OP_LOAD:  next_result = read_data;
            OP_STORE: next_result = y_value;           // Goes out as write_data
            OP_JMP:   next_result = pc + 1'b1;         // Link value
            OP_BRZ:   next_result = word_t'(y_zero);   // Taken flag in bit 0
            OP_SLT:
            begin
                if ($signed(x_value) < $signed(y_value))
                    next_result = word_t'(1);
                else
                    next_result = '0;
            end
            default:  next_result = '0;                // NOP
        endcase
    end

    // ---------------------------------------------------------------------
    // Result register
    // ---------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (!reset)
            result <= '0;
        else if (ctrl.result_load)
            result <= next_result; // End of EXECUTE
    end

endmodule

`default_nettype wire

// ==== src/controller.sv ====
// -------------------------------------------------------------------------
// Cycle state machine and instruction decoder. Steps through FETCH,
// DECODE, EXECUTE and STORE and drives the control bundle for the cycle.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  logic               clock,
    input  logic               reset,
    input  nbbpu_pkg::instr_t  instr,
    output nbbpu_pkg::ctrl_t   ctrl
);
    import nbbpu_pkg::*;

    state_t state;
    state_t next_state;
    logic   is_load;
    logic   is_store;
    logic   writes_reg;

    // ---------------------------------------------------------------------
    // State register
    // ---------------------------------------------------------------------

    always_comb
    begin
        case (state)
            FETCH:   next_state = DECODE;
            DECODE:  next_state = EXECUTE;
            EXECUTE: next_state = STORE;
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!reset)
            state <= FETCH;
        else
            state <= next_state;
    end

    // ---------------------------------------------------------------------
    // Decode
    // ---------------------------------------------------------------------

    assign is_load  = (instr.opcode == OP_LOAD);
    assign is_store = (instr.opcode == OP_STORE);

    // Everything except STORE, BRZ and NOP lands in reg z
    assign writes_reg = !(instr.opcode inside {OP_STORE, OP_BRZ, OP_NOP});

    always_comb
    begin
        ctrl = '0;

        // Strobes held to their own cycle
        ctrl.instruction_enable = (state == FETCH);
        ctrl.read_enable        = is_load && (state == EXECUTE);
        ctrl.result_load        = (state == EXECUTE);
        ctrl.write_enable       = is_store && (state == STORE);
        ctrl.reg_write          = writes_reg && (state == STORE);
        ctrl.pc_load            = (state == STORE);

        // Steering, valid for the whole instruction
        ctrl.reg_set = (instr.opcode == OP_SETL) || (instr.opcode == OP_SETH);
        ctrl.jump    = (instr.opcode == OP_JMP);
        ctrl.branch  = (instr.opcode == OP_BRZ);
    end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
// -------------------------------------------------------------------------
// Program counter and instruction register. Latches the fetched word at
// the end of FETCH and picks the next PC at the end of STORE.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nbbpu_cfg.svh"

module fetch_unit (
    input  logic               clock,
    input  logic               reset,
    input  nbbpu_pkg::ctrl_t   ctrl,
    input  nbbpu_pkg::word_t   instruction,
    input  nbbpu_pkg::word_t   x_value,
    input  nbbpu_pkg::word_t   result,
    output nbbpu_pkg::word_t   pc,
    output nbbpu_pkg::instr_t  instr
);

    logic take_target;

    // BRZ leaves its zero flag in bit 0 of the held result
    assign take_target = ctrl.jump || (ctrl.branch && result[0]);

    // Instruction register, reset to a NOP
    always_ff @(posedge clock)
    begin
        if (!reset)
            instr <= '{opcode: nbbpu_pkg::OP_NOP, x: '0, y: '0, z: '0};
        else if (ctrl.instruction_enable)
            instr <= nbbpu_pkg::instr_t'(instruction);
    end

    // ---------------------------------------------------------------------
    // Program counter
    // ---------------------------------------------------------------------

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            pc <= `NBBPU_RESET_PC;
        end
        else if (ctrl.pc_load)
        begin
            if (take_target)
                pc <= x_value; // Jump or taken branch
            else
                pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/nbbpu.sv ====
// -------------------------------------------------------------------------
// NBBPU top level. Connects controller, register file, ALU and fetch unit
// to the instruction and data memory ports. Memories sit outside and
// answer combinationally in the cycle of their enable.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nbbpu (
    input  logic               clock,
    input  logic               reset,
    input  nbbpu_pkg::word_t   instruction,
    input  nbbpu_pkg::word_t   read_data,
    output logic               instruction_enable,
    output logic               read_enable,
    output logic               write_enable,
    output nbbpu_pkg::word_t   address,
    output nbbpu_pkg::word_t   write_data,
    output nbbpu_pkg::word_t   pc,
    output logic               debug
);
    import nbbpu_pkg::*;

    ctrl_t  ctrl;
    instr_t instr;
    word_t  x_value;
    word_t  y_value;
    word_t  result;

    controller u_controller (
        .clock (clock),
        .reset (reset),
        .instr (instr),
        .ctrl  (ctrl)
    );

    regfile u_regfile (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (ctrl),
        .instr       (instr),
        .write_value (result),
        .x_value     (x_value),
        .y_value     (y_value)
    );

    alu u_alu (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .instr     (instr),
        .x_value   (x_value),
        .y_value   (y_value),
        .read_data (read_data),
        .pc        (pc),
        .result    (result)
    );

    fetch_unit u_fetch_unit (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (ctrl),
        .instruction (instruction),
        .x_value     (x_value),
        .result      (result),
        .pc          (pc),
        .instr       (instr)
    );

    // ---------------------------------------------------------------------
    // Memory ports
    // ---------------------------------------------------------------------

    assign instruction_enable = ctrl.instruction_enable;
    assign read_enable        = ctrl.read_enable;
    assign write_enable       = ctrl.write_enable;
    assign address            = x_value; // Reg x for LOAD and STORE
    assign write_data         = result;

    // Debug latch, set by writes with bit 15 high
    always_ff @(posedge clock)
    begin
        if (!reset)
            debug <= 1'b1;
        else if (write_enable && write_data[15])
            debug <= write_data[0];
    end

endmodule

`default_nettype wire

// ==== src/nbbpu_cfg.svh ====
// -------------------------------------------------------------------------
// Build-time sizes for the NBBPU processor core. Include this header in
// any file that needs the word width, register count or reset PC.
// -------------------------------------------------------------------------

`ifndef NBBPU_CFG_SVH
`define NBBPU_CFG_SVH

// -------------------------------------------------------------------------
// Datapath
// -------------------------------------------------------------------------

// Data and address words share one width
`define NBBPU_WIDTH 16

// General registers, indexed by the 4-bit x, y and z fields
`define NBBPU_REGS 16

// -------------------------------------------------------------------------
// Reset
// -------------------------------------------------------------------------

`define NBBPU_RESET_PC 16'h0000 // First fetch address

`endif

// ==== src/nbbpu_pkg.sv ====
// -------------------------------------------------------------------------
// Shared types for the NBBPU core: cycle states, opcodes, the instruction
// word layout and the control bundle sent from the controller.
// -------------------------------------------------------------------------
`default_nettype none

`include "nbbpu_cfg.svh"

package nbbpu_pkg;

    typedef logic [`NBBPU_WIDTH-1:0] word_t;
    typedef logic [$clog2(`NBBPU_REGS)-1:0] reg_addr_t;

    // Four cycles per instruction
    typedef enum logic [1:0] {
        FETCH   = 2'b00, // Instruction read from ROM
        DECODE  = 2'b01,
        EXECUTE = 2'b10, // ALU result and data read
        STORE   = 2'b11  // Register, RAM and PC update
    } state_t;

    typedef enum logic [3:0] {
        OP_AND   = 4'h0,
        OP_OR    = 4'h1,
        OP_XOR   = 4'h2,
        OP_NOT   = 4'h3,
        OP_ADD   = 4'h4,
        OP_SUB   = 4'h5,
        OP_SHL   = 4'h6,
        OP_SHR   = 4'h7,
        OP_SETL  = 4'h8, // Low byte of z from bits 11:4
        OP_SETH  = 4'h9, // High byte of z from bits 11:4
        OP_LOAD  = 4'ha,
        OP_STORE = 4'hb,
        OP_JMP   = 4'hc, // Link old PC plus 1 into z
        OP_BRZ   = 4'hd,
        OP_SLT   = 4'he, // Signed compare
        OP_NOP   = 4'hf
    } opcode_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t x;
        reg_addr_t y;
        reg_addr_t z;
    } instr_t;

    typedef struct packed {
        logic instruction_enable;
        logic read_enable;
        logic write_enable;
        logic reg_write;
        logic reg_set;     // Read z through port x
        logic result_load;
        logic pc_load;
        logic jump;
        logic branch;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== src/regfile.sv ====
// -------------------------------------------------------------------------
// General register file, two combinational read ports and one write port.
// Port x reads field z instead of x for the byte set instructions.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nbbpu_cfg.svh"

module regfile (
    input  logic               clock,
    input  logic               reset,
    input  nbbpu_pkg::ctrl_t   ctrl,
    input  nbbpu_pkg::instr_t  instr,
    input  nbbpu_pkg::word_t   write_value,
    output nbbpu_pkg::word_t   x_value,
    output nbbpu_pkg::word_t   y_value
);
    import nbbpu_pkg::*;

    word_t     regs [`NBBPU_REGS];
    reg_addr_t x_index;

    // SETL and SETH merge into the old contents of reg z
    assign x_index = ctrl.reg_set ? instr.z : instr.x;

    assign x_value = regs[x_index];
    assign y_value = regs[instr.y];

    always_ff @(posedge clock)
    begin
        if (!reset)
        begin
            for (int i = 0; i < `NBBPU_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (ctrl.reg_write)
        begin
            regs[instr.z] <= write_value; // End of STORE
        end
    end

endmodule

`default_nettype wire

// ==== verification/nbbpu_asserts.sv ====
// -------------------------------------------------------------------------
// Protocol checks on the NBBPU memory strobes. Bound into the core from
// the testbench; fetch, read and write cycles must keep the 4-cycle frame.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module nbbpu_asserts (
    input logic clock,
    input logic reset,
    input logic instruction_enable,
    input logic read_enable,
    input logic write_enable
);

    logic [2:0] since_reset; // Saturating count of cycles out of reset
    int         failures;    // Failed properties so far

    always_ff @(posedge clock)
    begin
        if (!reset)
            since_reset <= '0;
        else if (since_reset != 3'd7)
            since_reset <= since_reset + 3'd1;
    end

    // ---------------------------------------------------------------------
    // Strobe timing
    // ---------------------------------------------------------------------

    a_fetch_alone: assert property (@(posedge clock) disable iff (!reset)
        instruction_enable |-> !(read_enable || write_enable))
        else
        begin
            failures = failures + 1;
            $error("data strobe in the fetch cycle");
        end

    // STORE sits three cycles after its FETCH
    a_write_slot: assert property (@(posedge clock) disable iff (!reset)
        write_enable |-> (since_reset >= 3'd3 && $past(instruction_enable, 3)))
        else
        begin
            failures = failures + 1;
            $error("write strobe outside the STORE cycle");
        end

    a_fetch_gap: assert property (@(posedge clock) disable iff (!reset)
        (instruction_enable && since_reset >= 3'd3) |->
            !($past(instruction_enable, 1) || $past(instruction_enable, 2) ||
              $past(instruction_enable, 3)))
        else
        begin
            failures = failures + 1;
            $error("fetch strobes closer than 4 cycles");
        end

    a_fetch_period: assert property (@(posedge clock) disable iff (!reset)
        (since_reset >= 3'd4) |-> (instruction_enable == $past(instruction_enable, 4)))
        else
        begin
            failures = failures + 1;
            $error("fetch strobe does not recur every 4 cycles");
        end

endmodule

`default_nettype wire

// ==== verification/nbbpu_tb.sv ====
// -------------------------------------------------------------------------
// Testbench for the NBBPU core. Models the instruction ROM and data RAM,
// runs small directed programs and checks stores, fetch addresses, debug.
// -------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "nbbpu_cfg.svh"

module nbbpu_tb;
    import nbbpu_pkg::*;

    localparam int ROM_DEPTH = 256;
    localparam int TIMEOUT   = 1000; // Cycles allowed per wait

    logic  clock;
    logic  reset;
    word_t instruction;
    word_t read_data;
    logic  instruction_enable;
    logic  read_enable;
    logic  write_enable;
    word_t address;
    word_t write_data;
    word_t pc;
    logic  debug;

    word_t       rom [ROM_DEPTH];
    word_t       ram [2**`NBBPU_WIDTH];
    word_t       fetch_pcs [$];
    int          fetch_cycles [$];
    word_t       read_addrs [$];
    int          read_cycles [$];
    word_t       write_addrs [$];
    word_t       write_datas [$];
    int          cycle_count;
    logic [31:0] lcg_state;

    nbbpu dut (.*);

    bind nbbpu nbbpu_asserts u_asserts (
        .clock              (clock),
        .reset              (reset),
        .instruction_enable (instruction_enable),
        .read_enable        (read_enable),
        .write_enable       (write_enable)
    );

    // Zero-wait memories, ROM reads past its end as NOP
    assign instruction = (pc[15:8] == 8'h00) ? rom[pc[7:0]] : {OP_NOP, 12'h000};
    assign read_data   = ram[address];

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Fetches and RAM accesses recorded mid-cycle
    always @(negedge clock)
    begin
        cycle_count = cycle_count + 1;
        if (reset && instruction_enable)
        begin
            fetch_pcs.push_back(pc);
            fetch_cycles.push_back(cycle_count);
        end
        if (reset && read_enable)
        begin
            read_addrs.push_back(address);
            read_cycles.push_back(cycle_count);
        end
        if (reset && write_enable)
        begin
            write_addrs.push_back(address);
            write_datas.push_back(write_data);
            ram[address] = write_data;
        end
    end

    // ---------------------------------------------------------------------
    // Stimulus and reference model
    // ---------------------------------------------------------------------

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic word_t encode(opcode_t op, reg_addr_t x, reg_addr_t y, reg_addr_t z);
        return {op, x, y, z};
    endfunction

    function automatic word_t encode_set(opcode_t op, logic [7:0] imm, reg_addr_t z);
        return {op, imm, z}; // Byte spans the x and y fields
    endfunction

    function automatic word_t model_alu(opcode_t op, word_t a, word_t b);
        case (op)
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_NOT:  return ~a;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SHL:  return a << b[3:0];
            OP_SHR:  return a >> b[3:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: return 16'd0;
        endcase
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, expected));
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected)
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b",
                               $time, name, got, expected));
    endtask

    // Reset goes low here, the program is loaded while it stays low
    task automatic hold_reset();
        @(posedge clock);
        #5;
        reset = 1'b0;
        fetch_pcs.delete();
        fetch_cycles.delete();
        read_addrs.delete();
        read_cycles.delete();
        write_addrs.delete();
        write_datas.delete();
        for (int i = 0; i < ROM_DEPTH; i++)
            rom[i] = {OP_NOP, 12'h000};
    endtask

    task automatic release_reset();
        repeat (16) @(posedge clock);
        #5;
        reset = 1'b1;
    endtask

    // Returns once instruction count has been fetched, all before it done
    task automatic run_until(input int count);
        int waited;
        waited = 0;
        while (fetch_pcs.size() <= count)
        begin
            @(posedge clock);
            waited++;
            if (waited > TIMEOUT)
                fail_now($sformatf("timeout at %0t waiting for fetch %0d", $time, count));
        end
        #5;
    endtask

    // ---------------------------------------------------------------------
    // Directed tests
    // ---------------------------------------------------------------------

    task automatic test_reset_and_fetch();
        hold_reset();
        release_reset();
        check_word("pc", pc, 16'h0000);
        check_bit("debug", debug, 1'b1);
        check_bit("instruction_enable", instruction_enable, 1'b1);
        check_bit("read_enable", read_enable, 1'b0);
        check_bit("write_enable", write_enable, 1'b0);
        run_until(8);
        for (int i = 0; i <= 8; i++)
        begin
            check_word("pc", fetch_pcs[i], word_t'(i));
            if (i > 0)
                check_word("fetch spacing", word_t'(fetch_cycles[i] - fetch_cycles[i-1]), 16'd4);
        end
    endtask

    task automatic test_alu_ops();
        opcode_t ops [9];
        word_t   a_vals [3];
        word_t   b_vals [3];
        int      pos;
        ops = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_SLT};
        hold_reset();
        rom[0] = encode_set(OP_SETL, 8'h40, 4'd4); // Store address in r4
        pos = 1;
        for (int r = 0; r < 3; r++)
        begin
            a_vals[r] = next_random();
            b_vals[r] = next_random();
            rom[pos]     = encode_set(OP_SETL, a_vals[r][7:0], 4'd1);
            rom[pos + 1] = encode_set(OP_SETH, a_vals[r][15:8], 4'd1);
            rom[pos + 2] = encode_set(OP_SETL, b_vals[r][7:0], 4'd2);
            rom[pos + 3] = encode_set(OP_SETH, b_vals[r][15:8], 4'd2);
            pos += 4;
            for (int k = 0; k < 9; k++)
            begin
                rom[pos]     = encode(ops[k], 4'd1, 4'd2, 4'd3);
                rom[pos + 1] = encode(OP_STORE, 4'd4, 4'd3, 4'd0);
                pos += 2;
            end
        end
        release_reset();
        run_until(pos);
        check_word("read count", word_t'(read_addrs.size()), 16'd0);
        check_word("write count", word_t'(write_datas.size()), 16'd27);
        for (int r = 0; r < 3; r++)
            for (int k = 0; k < 9; k++)
            begin
                check_word("address", write_addrs[r*9 + k], 16'h0040);
                check_word("write_data", write_datas[r*9 + k],
                           model_alu(ops[k], a_vals[r], b_vals[r]));
            end
    endtask

    task automatic test_load_store();
        word_t value;
        value = next_random();
        hold_reset();
        ram[16'h0123] = value;
        rom[0] = encode_set(OP_SETL, 8'h23, 4'd1);
        rom[1] = encode_set(OP_SETH, 8'h01, 4'd1);
        rom[2] = encode(OP_LOAD, 4'd1, 4'd0, 4'd2);  // r2 = ram[0x0123]
        rom[3] = encode_set(OP_SETL, 8'h80, 4'd3);
        rom[4] = encode_set(OP_SETH, 8'h02, 4'd3);
        rom[5] = encode(OP_STORE, 4'd3, 4'd2, 4'd0); // ram[0x0280] = r2
        release_reset();
        run_until(6);
        check_word("read count", word_t'(read_addrs.size()), 16'd1);
        check_word("address", read_addrs[0], 16'h0123);
        check_word("read spacing", word_t'(read_cycles[0] - fetch_cycles[2]), 16'd2);
        check_word("write count", word_t'(write_datas.size()), 16'd1);
        check_word("address", write_addrs[0], 16'h0280);
        check_word("write_data", write_datas[0], value);
    endtask

    task automatic test_control_flow();
        word_t expected_pcs [9];
        expected_pcs = '{16'h00, 16'h01, 16'h08, 16'h09, 16'h0a, 16'h0b, 16'h20, 16'h21, 16'h22};
        hold_reset();
        rom[0]     = encode_set(OP_SETL, 8'h08, 4'd1);
        rom[1]     = encode(OP_BRZ, 4'd1, 4'd2, 4'd0);  // r2 is zero, taken
        rom[8]     = encode_set(OP_SETL, 8'h01, 4'd2);
        rom[9]     = encode(OP_BRZ, 4'd1, 4'd2, 4'd0);  // Not taken
        rom[10]    = encode_set(OP_SETL, 8'h20, 4'd3);
        rom[11]    = encode(OP_JMP, 4'd3, 4'd0, 4'd5);  // Link 12 into r5
        rom[8'h20] = encode_set(OP_SETL, 8'h50, 4'd4);
        rom[8'h21] = encode(OP_STORE, 4'd4, 4'd5, 4'd0);
        release_reset();
        run_until(8);
        for (int i = 0; i < 9; i++)
            check_word("pc", fetch_pcs[i], expected_pcs[i]);
        check_word("write count", word_t'(write_datas.size()), 16'd1);
        check_word("address", write_addrs[0], 16'h0050);
        check_word("write_data", write_datas[0], 16'h000c);
    endtask

    task automatic test_debug_latch();
        hold_reset();
        rom[0] = encode_set(OP_SETL, 8'h10, 4'd1);
        rom[1] = encode_set(OP_SETH, 8'h80, 4'd2);   // r2 = 0x8000
        rom[2] = encode(OP_STORE, 4'd1, 4'd2, 4'd0);
        rom[3] = encode_set(OP_SETL, 8'h01, 4'd3);   // r3 = 0x0001
        rom[4] = encode(OP_STORE, 4'd1, 4'd3, 4'd0);
        rom[5] = encode_set(OP_SETH, 8'h80, 4'd3);   // r3 = 0x8001
        rom[6] = encode(OP_STORE, 4'd1, 4'd3, 4'd0);
        release_reset();
        run_until(3);
        check_bit("debug", debug, 1'b0);
        run_until(5);
        check_bit("debug", debug, 1'b0);
        run_until(7);
        check_bit("debug", debug, 1'b1);
        check_word("write count", word_t'(write_datas.size()), 16'd3);
    endtask

    initial
    begin
        reset       = 1'b0;
        cycle_count = 0;
        lcg_state   = 32'd77983;
        for (int i = 0; i < ROM_DEPTH; i++)
            rom[i] = {OP_NOP, 12'h000};
        for (int i = 0; i < 2**`NBBPU_WIDTH; i++)
            ram[i] = word_t'(i * 40503) ^ 16'h5a5a; // Odd multiplier keeps words distinct

        test_reset_and_fetch();
        test_alu_ops();
        test_load_store();
        test_control_flow();
        test_debug_latch();

        if (dut.u_asserts.failures == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
